/* fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

    // ************************************************************************
    // sizes and thresholds
    // ************************************************************************
    localparam int DEPTH_W = 4;                 // address bits
    localparam int DEPTH   = 1 << DEPTH_W;      // 16 words
    localparam int DATA_W  = 16;                // payload bits

    // flag thresholds against the water level
    localparam int ALMOST_FULL_NUM  = 12;       // at or above -> almost_full
    localparam int ALMOST_EMPTY_NUM = 2;        // at or below -> almost_empty

    // ************************************************************************
    // types
    // ************************************************************************
    typedef logic [DEPTH_W-1:0] addr_t;         // storage address
    typedef logic [DEPTH_W:0]   ptr_t;          // msb is the wrap bit
    typedef logic [DEPTH_W:0]   level_t;        // 0 .. 16
    typedef logic [DATA_W-1:0]  data_t;

    // status bundle, as seen at the top level
    typedef struct packed {
        logic   full;
        logic   almost_full;
        logic   empty;
        logic   almost_empty;
        level_t level;
    } fifo_stat_t;

endpackage

`default_nettype wire

/* fifo_wr_ptr.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_wr_ptr (
    input  wire logic           rclk,
    input  wire logic           rrst,
    input  wire logic           w_en,
    input  wire logic           full,       // registered flag from status
    output fifo_pkg::ptr_t      wr_next,
    output fifo_pkg::addr_t     waddr,
    output logic                wr_strobe
);

    import fifo_pkg::*;

    ptr_t wr_ptr;                           // current write pointer, wrap bit on top

    // ************************************************************************
    // next write pointer
    // ************************************************************************
    always_comb
    begin
        if (!full)
        begin
            wr_next = wr_ptr + ptr_t'(w_en);    // step only on a strobe
        end
        else
        begin
            wr_next = wr_ptr;                   // write refused while full
        end
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            wr_ptr <= '0;
        end
        else
        begin
            wr_ptr <= wr_next;
        end
    end

    // storage side
    assign wr_strobe = w_en & ~full;            // accepted write
    assign waddr     = wr_ptr[DEPTH_W-1:0];     // slot being filled, wrap bit dropped

endmodule

`default_nettype wire

/* fifo_rd_ptr.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_rd_ptr (
    input  wire logic           rclk,
    input  wire logic           rrst,
    input  wire logic           r_en,
    input  wire logic           empty,      // registered flag from status
    output fifo_pkg::ptr_t      rd_next,
    output fifo_pkg::addr_t     raddr
);

    import fifo_pkg::*;

    ptr_t rd_ptr;                           // holds rd_next as taken at the last edge

    // ************************************************************************
    // next read pointer, mirror of the write side
    // ************************************************************************
    always_comb
    begin
        if (!empty)
            rd_next = rd_ptr + ptr_t'(r_en);    // pop on strobe
        else
            rd_next = rd_ptr;                   // nothing to pop
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            rd_ptr <= '0;
        else
            rd_ptr <= rd_next;
    end

    // next pointer captured at the edge, so the comb read
    // shows the new head right after a pop
    assign raddr = rd_ptr[DEPTH_W-1:0];

endmodule

`default_nettype wire

/* fifo_status.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_status (
    input  wire logic           rclk,
    input  wire logic           rrst,
    input  fifo_pkg::ptr_t      wr_next,
    input  fifo_pkg::ptr_t      rd_next,
    output fifo_pkg::fifo_stat_t stat
);

    import fifo_pkg::*;

    // compare results, all from the next pointers
    logic   wrap_diff;                      // writer is one lap ahead
    logic   low_match;                      // same slot
    logic   full_d;
    logic   empty_d;
    level_t level_d;

    // registered state
    logic   full_q;
    logic   empty_q;
    level_t level_q;

    // ************************************************************************
    // pointer compare
    // ************************************************************************
    assign wrap_diff = wr_next[DEPTH_W] ^ rd_next[DEPTH_W];
    assign low_match = (wr_next[DEPTH_W-1:0] == rd_next[DEPTH_W-1:0]);

    assign full_d  = wrap_diff & low_match;     // one lap apart, same slot
    assign empty_d = ~wrap_diff & low_match;    // pointers equal

    // the four wrap-bit cases all fold into one subtraction mod 32;
    // a carry into the wrap bit covers the writer having lapped
    assign level_d = level_t'(wr_next - rd_next);

    // ************************************************************************
    // flag registers
    // ************************************************************************
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            full_q  <= 1'b0;
            empty_q <= 1'b1;                    // comes up empty
            level_q <= '0;
        end
        else
        begin
            full_q  <= full_d;
            empty_q <= empty_d;
            level_q <= level_d;
        end
    end

    // ************************************************************************
    // status bundle
    // ************************************************************************
    always_comb
    begin
        stat.full         = full_q;
        stat.empty        = empty_q;
        stat.level        = level_q;
        // thresholds against the registered level
        stat.almost_full  = (level_q >= level_t'(ALMOST_FULL_NUM));
        stat.almost_empty = (level_q <= level_t'(ALMOST_EMPTY_NUM));
    end

endmodule

`default_nettype wire

/* fifo_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_ram (
    input  wire logic           rclk,
    input  wire logic           wr_strobe,  // accepted write this cycle
    input  fifo_pkg::addr_t     waddr,
    input  fifo_pkg::data_t     wdata,
    input  fifo_pkg::addr_t     raddr,
    output fifo_pkg::data_t     rdata
);

    import fifo_pkg::*;

    // ************************************************************************
    // storage array, 16 words
    // ************************************************************************
    data_t mem [0:DEPTH-1];

    // write port, one word per edge
    always_ff @(posedge rclk)
    begin
        if (wr_strobe)
        begin
            mem[waddr] <= wdata;
        end
    end

    // read port is combinational, so the head is visible at once
    // (first word falls through with no extra cycle)
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* sfifo_top.sv */
`timescale 1ns/10ps
`default_nettype none

module sfifo_top (
    input  wire logic           rclk,
    input  wire logic           rrst,
    input  wire logic           w_en,
    input  fifo_pkg::data_t     wdata,
    input  wire logic           r_en,
    output fifo_pkg::data_t     rdata,
    output fifo_pkg::fifo_stat_t stat
);

    import fifo_pkg::*;

    // ************************************************************************
    // internal wires
    // ************************************************************************
    ptr_t  wr_next;                         // to status
    ptr_t  rd_next;                         // to status
    addr_t waddr;
    addr_t raddr;
    logic  wr_strobe;

    // write side, gated by full only
    fifo_wr_ptr i_fifo_wr_ptr (
        .rclk      (rclk),
        .rrst      (rrst),
        .w_en      (w_en),
        .full      (stat.full),
        .wr_next   (wr_next),
        .waddr     (waddr),
        .wr_strobe (wr_strobe)
    );

    // read side, gated by empty only
    fifo_rd_ptr i_fifo_rd_ptr (
        .rclk    (rclk),
        .rrst    (rrst),
        .r_en    (r_en),
        .empty   (stat.empty),
        .rd_next (rd_next),
        .raddr   (raddr)
    );

    // flags and level from both next pointers
    fifo_status i_fifo_status (
        .rclk    (rclk),
        .rrst    (rrst),
        .wr_next (wr_next),
        .rd_next (rd_next),
        .stat    (stat)
    );

    fifo_ram i_fifo_ram (
        .rclk      (rclk),
        .wr_strobe (wr_strobe),
        .waddr     (waddr),
        .wdata     (wdata),
        .raddr     (raddr),
        .rdata     (rdata)
    );

endmodule

`default_nettype wire

/* tb_sfifo.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sfifo;

    import fifo_pkg::*;

    // ************************************************************************
    // test table
    // ************************************************************************
    // strobe modes: 0 never, 1 always, 2 half, 3 quarter, 4 three quarters
    typedef struct packed {
        logic [15:0] cycles;
        logic [2:0]  w_mode;
        logic [2:0]  r_mode;
        logic        fixed;                 // end state known in advance
        logic        full;
        logic        empty;
        level_t      level;
    } row_t;

    localparam int          N_ROWS = 11;
    localparam logic [31:0] SEED   = 32'h6a63cb5a;

    logic        rclk;
    logic        rrst;
    logic        w_en;
    logic        r_en;
    data_t       wdata;
    data_t       rdata;
    fifo_stat_t  stat;

    row_t        rows [0:N_ROWS-1];
    data_t       model_q [$];               // reference contents, oldest first
    logic [31:0] rng;
    int          n_checks;
    int          n_errors;

    sfifo_top i_sfifo_top (
        .rclk  (rclk),
        .rrst  (rrst),
        .w_en  (w_en),
        .wdata (wdata),
        .r_en  (r_en),
        .rdata (rdata),
        .stat  (stat)
    );

    always #5 rclk = ~rclk;                 // 10 ns period

    // ************************************************************************
    // helpers
    // ************************************************************************
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic strobe_from_mode(input logic [2:0] mode, input logic [7:0] r);
        case (mode)
            3'd0:    return 1'b0;
            3'd1:    return 1'b1;
            3'd2:    return r < 8'd128;
            3'd3:    return r < 8'd64;
            default: return r < 8'd192;
        endcase
    endfunction

    function automatic row_t make_row(input int cycles, input int w, input int r,
                                      input logic fixed, input logic full,
                                      input logic empty, input int level);
        row_t row;
        row.cycles = 16'(cycles);
        row.w_mode = 3'(w);
        row.r_mode = 3'(r);
        row.fixed  = fixed;
        row.full   = full;
        row.empty  = empty;
        row.level  = level_t'(level);
        return row;
    endfunction

    // flags as the status rules give them for n stored words
    function automatic fifo_stat_t stat_for_level(input int n);
        fifo_stat_t s;
        s.level        = level_t'(n);
        s.full         = (n == DEPTH);
        s.empty        = (n == 0);
        s.almost_full  = (n >= ALMOST_FULL_NUM);
        s.almost_empty = (n <= ALMOST_EMPTY_NUM);
        return s;
    endfunction

    function automatic string stat_text(input fifo_stat_t s);
        return $sformatf("full=%b af=%b empty=%b ae=%b level=%0d",
                         s.full, s.almost_full, s.empty, s.almost_empty, s.level);
    endfunction

    task automatic load_table();
        rows[0]  = make_row(12,  1, 0, 1'b1, 1'b0, 1'b0, 12);  // up to almost_full
        rows[1]  = make_row(4,   1, 0, 1'b1, 1'b1, 1'b0, 16);  // full
        rows[2]  = make_row(5,   1, 0, 1'b1, 1'b1, 1'b0, 16);  // writes refused
        rows[3]  = make_row(8,   0, 1, 1'b1, 1'b0, 1'b0, 8);   // half drain
        rows[4]  = make_row(20,  1, 1, 1'b1, 1'b0, 1'b0, 8);   // both, level holds
        rows[5]  = make_row(10,  0, 1, 1'b1, 1'b0, 1'b1, 0);   // reads refused at end
        rows[6]  = make_row(5,   1, 1, 1'b1, 1'b0, 1'b0, 1);   // first read refused
        rows[7]  = make_row(300, 4, 2, 1'b0, 1'b0, 1'b0, 0);   // random, leans full
        rows[8]  = make_row(300, 3, 4, 1'b0, 1'b0, 1'b0, 0);   // random, leans empty
        rows[9]  = make_row(200, 2, 2, 1'b0, 1'b0, 1'b0, 0);
        rows[10] = make_row(20,  0, 1, 1'b1, 1'b0, 1'b1, 0);   // final drain
    endtask

    // ************************************************************************
    // compare tasks
    // ************************************************************************
    task automatic compare_stat(input string name, input fifo_stat_t got,
                                input fifo_stat_t exp);
        n_checks = n_checks + 1;
        if (got !== exp)
        begin
            n_errors = n_errors + 1;
            $display("FAIL %0d ns %s got {%s} expected {%s}", $time, name,
                     stat_text(got), stat_text(exp));
        end
    endtask

    task automatic compare_word(input string name, input data_t got, input data_t exp);
        n_checks = n_checks + 1;
        if (got !== exp)
        begin
            n_errors = n_errors + 1;
            $display("FAIL %0d ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one edge: drive, check the state left by the previous edge, step the model
    task automatic run_cycle(input logic we, input logic re);
        data_t wd;
        logic  acc_w;
        logic  acc_r;
        rng = xorshift32(rng);
        wd  = rng[31:16];
        @(posedge rclk);
        w_en  <= we;
        r_en  <= re;
        wdata <= wd;
        @(negedge rclk);                    // outputs settled
        compare_stat("stat", stat, stat_for_level(model_q.size()));
        if (model_q.size() > 0)
            compare_word("rdata", rdata, model_q[0]);   // head only when defined
        acc_w = we && (model_q.size() < DEPTH);         // refused while full
        acc_r = re && (model_q.size() > 0);             // refused while empty
        if (acc_r)
            void'(model_q.pop_front());
        if (acc_w)
            model_q.push_back(wd);
    endtask

    // ************************************************************************
    // main sequence
    // ************************************************************************
    initial
    begin
        int         i;
        int         c;
        int         err_start;
        logic       we;
        logic       re;
        fifo_stat_t exp;

        rclk     = 1'b0;
        rrst     = 1'b1;
        w_en     = 1'b0;
        r_en     = 1'b0;
        wdata    = '0;
        rng      = SEED;
        n_checks = 0;
        n_errors = 0;
        load_table();

        repeat (8) @(posedge rclk);
        rrst <= 1'b0;
        @(negedge rclk);
        compare_stat("stat after reset", stat, stat_for_level(0));
        $display("reset: errors %0d", n_errors);

        for (i = 0; i < N_ROWS; i++)
        begin
            err_start = n_errors;
            for (c = 0; c < int'(rows[i].cycles); c++)
            begin
                rng = xorshift32(rng);
                we  = strobe_from_mode(rows[i].w_mode, rng[7:0]);
                re  = strobe_from_mode(rows[i].r_mode, rng[15:8]);
                run_cycle(we, re);
            end
            run_cycle(1'b0, 1'b0);          // idle edge, row's last op now visible
            if (rows[i].fixed)
            begin
                exp       = stat_for_level(int'(rows[i].level));
                exp.full  = rows[i].full;
                exp.empty = rows[i].empty;
                compare_stat("stat at row end", stat, exp);
            end
            $display("row %0d: %0d cycles, w mode %0d, r mode %0d, level %0d, new errors %0d",
                     i, rows[i].cycles, rows[i].w_mode, rows[i].r_mode, stat.level,
                     n_errors - err_start);
        end

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // watchdog, twice the table length plus reset
    initial
    begin
        int total;
        int k;
        total = 0;
        #1;                                 // table loaded at time 0
        for (k = 0; k < N_ROWS; k++)
            total = total + int'(rows[k].cycles);
        #(2 * total * 10 + 8 * 10);
        $display("timeout: the table did not finish within %0d ns", 2 * total * 10 + 80);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
fifo_pkg.sv
fifo_wr_ptr.sv
fifo_rd_ptr.sv
fifo_status.sv
fifo_ram.sv
sfifo_top.sv
tb_sfifo.sv

/* Makefile */
# Verilator build and run of the FIFO testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build tb_sfifo with Verilator, run it, log to $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_sfifo \
		-f list.f -Mdir obj_dir
	./obj_dir/Vtb_sfifo | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
